//--- src/fib_pkg.sv
`default_nettype none

package fib_pkg;

    // Field widths
    localparam int prefix_w = 64;
    localparam int len_w    = 6;
    localparam int face_w   = 4;
    localparam int tag_w    = 8;

    // Lookup request from the PIT, 78 bits
    typedef struct packed {
        logic [prefix_w-1:0] prefix;
        logic [len_w-1:0]    len;
        logic [tag_w-1:0]    tag;
    } fib_req_t;

    // Lookup answer, 19 bits
    // Miss gives hit 0 with face and match_len zero
    typedef struct packed {
        logic [tag_w-1:0] tag;
        logic             hit;
        logic [face_w-1:0] face;
        logic [len_w-1:0] match_len;
    } fib_rsp_t;

    // One forwarding table entry, 75 bits
    // Length counts leading prefix bits, 0 is the default route
    typedef struct packed {
        logic                valid;
        logic [prefix_w-1:0] prefix;
        logic [len_w-1:0]    len;
        logic [face_w-1:0]   face;
    } fib_entry_t;

endpackage

`default_nettype wire

//--- src/fib_table_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fib_table_if #(
    parameter int num_entries = 8
) (
    input logic clk
);
    import fib_pkg::*;

    // Whole table, entry i at index i
    fib_entry_t [num_entries-1:0] entries;

    // High for one cycle after the table has been rewritten
    logic table_version;

    // Register block side
    modport regs (
        input  clk,
        output entries,
        output table_version
    );

    // Match pipeline side
    modport lookup (
        input clk,
        input entries,
        input table_version
    );

endinterface

`default_nettype wire

//--- src/fib_table_regs.sv
`timescale 1ns/1ps
`default_nettype none

module fib_table_regs #(
    parameter int num_entries = 8
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         cfg_write,
    input  logic [$clog2(num_entries)-1:0] cfg_index,
    input  fib_pkg::fib_entry_t          cfg_entry,
    fib_table_if.regs                    tbl
);

    localparam int idx_w = $clog2(num_entries);

    logic [idx_w-1:0] wr_idx;

    assign wr_idx = cfg_index;

    // Table storage lives in the interface so the matcher sees every entry at once
    always_ff @(posedge clk) begin
        if (reset) begin
            // Empty table, every entry invalid
            tbl.entries       <= '0;
            tbl.table_version <= 1'b0;
        end else begin
            tbl.table_version <= cfg_write;
            if (cfg_write) begin
                // Whole entry replaced; valid 0 deletes it
                tbl.entries[wr_idx] <= cfg_entry;
            end
        end
    end

    // Config index must address an existing entry
    a_cfg_index_range: assert property (
        @(posedge clk) disable iff (reset)
        cfg_write |-> (int'(cfg_index) < num_entries)
    );

endmodule

`default_nettype wire

//--- src/fib_credit_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module fib_credit_buffer #(
    parameter type payload_t    = logic,
    parameter int  depth        = 4,
    parameter int  init_credits = 4
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_credit,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_credit
);

    localparam int ptr_w  = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w  = $clog2(depth + 1);
    localparam int cred_w = $clog2(init_credits + 1);

    payload_t mem [depth];

    logic [ptr_w-1:0]  wr_ptr;
    logic [ptr_w-1:0]  rd_ptr;
    logic [cnt_w-1:0]  count;
    logic [cred_w-1:0] credits;
    logic              push;
    logic              pop;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Sender already holds a slot for every valid it raises
    assign push = in_valid;

    // Send whenever there is data and downstream credit
    assign pop = (count != '0) && (credits != '0);

    assign out_valid = pop;
    assign out_data  = mem[rd_ptr];

    // Slot freed by this pop goes straight back upstream
    assign in_credit = pop;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= cred_w'(init_credits);
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count   <= count + cnt_w'(push) - cnt_w'(pop);
            credits <= credits + cred_w'(out_credit) - cred_w'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // Upstream credit accounting keeps pushes off a full FIFO
    a_no_push_full: assert property (
        @(posedge clk) disable iff (reset)
        in_valid |-> (int'(count) < depth)
    );

    // Downstream never returns more credits than it granted
    a_credit_bound: assert property (
        @(posedge clk) disable iff (reset)
        int'(credits) <= init_credits
    );

endmodule

`default_nettype wire

//--- src/fib_lpm_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module fib_lpm_lookup #(
    parameter int num_entries = 8
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    input  fib_pkg::fib_req_t in_req,
    fib_table_if.lookup       tbl,
    output logic              out_valid,
    output fib_pkg::fib_rsp_t out_rsp
);

    import fib_pkg::*;

    localparam int idx_w = (num_entries > 1) ? $clog2(num_entries) : 1;

    // Stage 1 inputs
    logic [num_entries-1:0] cover_d;

    // Stage 1 registers
    logic                   s1_valid;
    logic [tag_w-1:0]       s1_tag;
    logic [num_entries-1:0] s1_cover;
    logic [len_w-1:0]       s1_len  [num_entries];
    logic [face_w-1:0]      s1_face [num_entries];

    // Stage 2 selection
    logic             best_hit;
    logic [idx_w-1:0] best_idx;

    // Entry covers the request when its leading len bits agree
    function automatic logic entry_covers(input fib_entry_t e, input fib_req_t r);
        logic [prefix_w-1:0] mask;
        mask = ~({prefix_w{1'b1}} >> e.len);
        return e.valid && (e.len <= r.len) && (((e.prefix ^ r.prefix) & mask) == '0);
    endfunction

    always_comb begin
        for (int i = 0; i < num_entries; i++) begin
            cover_d[i] = entry_covers(tbl.entries[i], in_req);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    // Lengths and faces are captured with the cover vector so a config
    // write between the stages cannot mix two table versions
    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_tag   <= in_req.tag;
            s1_cover <= cover_d;
            for (int i = 0; i < num_entries; i++) begin
                s1_len[i]  <= tbl.entries[i].len;
                s1_face[i] <= tbl.entries[i].face;
            end
        end
    end

    // Longest cover wins; strict compare keeps the lowest index on a tie
    always_comb begin
        best_hit = 1'b0;
        best_idx = '0;
        for (int i = 0; i < num_entries; i++) begin
            if (s1_cover[i] && (!best_hit || (s1_len[i] > s1_len[best_idx]))) begin
                best_hit = 1'b1;
                best_idx = idx_w'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        out_rsp.tag       <= s1_tag;
        out_rsp.hit       <= best_hit;
        out_rsp.face      <= best_hit ? s1_face[best_idx] : '0;
        out_rsp.match_len <= best_hit ? s1_len[best_idx] : '0;
    end

    // Fixed two-cycle latency, nothing held back
    a_latency: assert property (
        @(posedge clk) disable iff (reset)
        out_valid == $past(in_valid, 2)
    );

    // Table only changes together with a version pulse from the register block
    a_table_version: assert property (
        @(posedge tbl.clk) disable iff (reset)
        !tbl.table_version |-> $stable(tbl.entries)
    );

endmodule

`default_nettype wire

//--- src/fib.sv
`timescale 1ns/1ps
`default_nettype none

module fib #(
    parameter int num_entries  = 8,
    parameter int in_depth     = 4,
    parameter int out_depth    = 4,
    parameter int down_credits = 4
) (
    input  logic                           clk,
    input  logic                           reset,
    // Table configuration
    input  logic                           cfg_write,
    input  logic [$clog2(num_entries)-1:0] cfg_index,
    input  logic                           cfg_valid,
    input  logic [fib_pkg::prefix_w-1:0]   cfg_prefix,
    input  logic [fib_pkg::len_w-1:0]      cfg_len,
    input  logic [fib_pkg::face_w-1:0]     cfg_face,
    // Requests from the PIT
    input  logic                           req_valid,
    input  logic [fib_pkg::prefix_w-1:0]   req_prefix,
    input  logic [fib_pkg::len_w-1:0]      req_len,
    input  logic [fib_pkg::tag_w-1:0]      req_tag,
    output logic                           req_credit,
    // Responses downstream
    output logic                           rsp_valid,
    output logic [fib_pkg::tag_w-1:0]      rsp_tag,
    output logic                           rsp_hit,
    output logic [fib_pkg::face_w-1:0]     rsp_face,
    output logic [fib_pkg::len_w-1:0]      rsp_match_len,
    input  logic                           rsp_credit
);

    import fib_pkg::*;

    fib_entry_t cfg_entry;
    fib_req_t   req_in;
    fib_req_t   lkp_req;
    fib_rsp_t   lkp_rsp;
    fib_rsp_t   rsp_out;
    logic       lkp_in_valid;
    logic       lkp_out_valid;
    logic       lkp_credit;

    assign cfg_entry.valid  = cfg_valid;
    assign cfg_entry.prefix = cfg_prefix;
    assign cfg_entry.len    = cfg_len;
    assign cfg_entry.face   = cfg_face;

    assign req_in.prefix = req_prefix;
    assign req_in.len    = req_len;
    assign req_in.tag    = req_tag;

    fib_table_if #(.num_entries(num_entries)) tbl_if (.clk(clk));

    fib_table_regs #(.num_entries(num_entries)) table_regs (
        .clk       (clk),
        .reset     (reset),
        .cfg_write (cfg_write),
        .cfg_index (cfg_index),
        .cfg_entry (cfg_entry),
        .tbl       (tbl_if.regs)
    );

    // Sends only against free slots in out_buf, so the pipeline never stalls
    fib_credit_buffer #(
        .payload_t    (fib_req_t),
        .depth        (in_depth),
        .init_credits (out_depth)
    ) in_buf (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (req_valid),
        .in_data    (req_in),
        .in_credit  (req_credit),
        .out_valid  (lkp_in_valid),
        .out_data   (lkp_req),
        .out_credit (lkp_credit)
    );

    fib_lpm_lookup #(.num_entries(num_entries)) lpm_lookup (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (lkp_in_valid),
        .in_req    (lkp_req),
        .tbl       (tbl_if.lookup),
        .out_valid (lkp_out_valid),
        .out_rsp   (lkp_rsp)
    );

    fib_credit_buffer #(
        .payload_t    (fib_rsp_t),
        .depth        (out_depth),
        .init_credits (down_credits)
    ) out_buf (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (lkp_out_valid),
        .in_data    (lkp_rsp),
        .in_credit  (lkp_credit),
        .out_valid  (rsp_valid),
        .out_data   (rsp_out),
        .out_credit (rsp_credit)
    );

    assign rsp_tag       = rsp_out.tag;
    assign rsp_hit       = rsp_out.hit;
    assign rsp_face      = rsp_out.face;
    assign rsp_match_len = rsp_out.match_len;

endmodule

`default_nettype wire

//--- testbench/fib_tb_checks.svh
`ifndef FIB_TB_CHECKS_SVH
`define FIB_TB_CHECKS_SVH

    // Response fields checked one at a time against the expected answer
    task automatic check_rsp(input fib_rsp_t got, input fib_rsp_t want);
        if (got.tag !== want.tag) begin
            $display("MISMATCH t=%0t rsp_tag got %0d expected %0d",
                     $time, got.tag, want.tag);
            abort_run();
        end else if (got.hit !== want.hit) begin
            $display("MISMATCH t=%0t rsp_hit (tag %0d) got %0b expected %0b",
                     $time, got.tag, got.hit, want.hit);
            abort_run();
        end else if (got.face !== want.face) begin
            $display("MISMATCH t=%0t rsp_face (tag %0d) got %0d expected %0d",
                     $time, got.tag, got.face, want.face);
            abort_run();
        end else if (got.match_len !== want.match_len) begin
            $display("MISMATCH t=%0t rsp_match_len (tag %0d) got %0d expected %0d",
                     $time, got.tag, got.match_len, want.match_len);
            abort_run();
        end
    endtask

    // Event totals counted at the DUT ports
    task automatic check_count(input string name, input int got, input int want);
        if (got != want) begin
            $display("MISMATCH t=%0t %s got %0d expected %0d", $time, name, got, want);
            abort_run();
        end
    endtask

`endif

//--- testbench/fib_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fib_tb;

    import fib_pkg::*;

    localparam int num_entries  = 8;
    localparam int in_depth     = 4;
    localparam int out_depth    = 4;
    localparam int down_credits = 4;
    localparam int wait_limit   = 400;
    localparam int hold_cycles  = 40;
    localparam logic [prefix_w-1:0] name_p = 64'hA1B2_C3D4_E5F6_0718;

    // Config write, or lookup with its expected answer in want
    typedef struct {
        logic                           is_cfg;
        logic [$clog2(num_entries)-1:0] index;
        logic                           valid;
        logic [prefix_w-1:0]            prefix;
        logic [len_w-1:0]               len;
        logic [face_w-1:0]              face;
        fib_rsp_t                       want;
    } stim_row_t;

    logic clk = 1'b0;
    logic reset;
    logic cfg_write;
    logic [$clog2(num_entries)-1:0] cfg_index;
    logic cfg_valid;
    logic [prefix_w-1:0] cfg_prefix;
    logic [len_w-1:0] cfg_len;
    logic [face_w-1:0] cfg_face;
    logic req_valid;
    logic [prefix_w-1:0] req_prefix;
    logic [len_w-1:0] req_len;
    logic [tag_w-1:0] req_tag;
    logic req_credit;
    logic rsp_valid;
    logic [tag_w-1:0] rsp_tag;
    logic rsp_hit;
    logic [face_w-1:0] rsp_face;
    logic [len_w-1:0] rsp_match_len;
    logic rsp_credit = 1'b0;

    stim_row_t stim[$];
    stim_row_t burst[$];
    fib_rsp_t expected[$];
    int return_due[$];
    int cycle = 0;
    int credit_pulses = 0;
    int rsp_count = 0;
    int rsp_returned = 0;
    int sent_count = 0;
    int errors = 0;
    logic hold_credits = 1'b0;
    logic [tag_w-1:0] next_tag;

    fib #(
        .num_entries  (num_entries),
        .in_depth     (in_depth),
        .out_depth    (out_depth),
        .down_credits (down_credits)
    ) fib_inst (.*);

    always #2 clk = ~clk;

    task automatic abort_run();
        errors++;
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    `include "fib_tb_checks.svh"

    function automatic stim_row_t cfg_row(input logic [$clog2(num_entries)-1:0] idx,
            input logic valid, input logic [prefix_w-1:0] prefix,
            input logic [len_w-1:0] len, input logic [face_w-1:0] face);
        stim_row_t row;
        row.is_cfg = 1'b1;
        row.index  = idx;
        row.valid  = valid;
        row.prefix = prefix;
        row.len    = len;
        row.face   = face;
        row.want   = '0;
        return row;
    endfunction

    function automatic stim_row_t lookup_row(input logic [prefix_w-1:0] prefix,
            input logic [len_w-1:0] len, input logic hit, input logic [face_w-1:0] face,
            input logic [len_w-1:0] match_len);
        stim_row_t row;
        row.is_cfg         = 1'b0;
        row.index          = '0;
        row.valid          = 1'b0;
        row.prefix         = prefix;
        row.len            = len;
        row.face           = '0;
        row.want.tag       = '0;
        row.want.hit       = hit;
        row.want.face      = face;
        row.want.match_len = match_len;
        return row;
    endfunction

    function automatic int upstream_credits();
        return in_depth + credit_pulses - sent_count;
    endfunction

    // Response scoreboard and credit bookkeeping
    always @(posedge clk) begin
        fib_rsp_t got;
        if (!reset) begin
            if (rsp_valid) begin
                if (expected.size() == 0) begin
                    $display("Response with tag %0d arrived with no request outstanding",
                             rsp_tag);
                    abort_run();
                end else begin
                    got.tag       = rsp_tag;
                    got.hit       = rsp_hit;
                    got.face      = rsp_face;
                    got.match_len = rsp_match_len;
                    check_rsp(got, expected.pop_front());
                    rsp_count = rsp_count + 1;
                    return_due.push_back(cycle + int'($urandom_range(6, 0)));
                end
            end
            if (rsp_count > down_credits + rsp_returned) begin
                $display("More responses were sent than downstream credits granted");
                abort_run();
            end
            if (rsp_credit) rsp_returned = rsp_returned + 1;
            if (req_credit) credit_pulses = credit_pulses + 1;
        end
        cycle = cycle + 1;
    end

    // Downstream returns one credit per cycle once its delay has run out
    always @(negedge clk) begin
        if (!reset && !hold_credits && return_due.size() > 0 && return_due[0] <= cycle) begin
            return_due.delete(0);
            rsp_credit = 1'b1;
        end else begin
            rsp_credit = 1'b0;
        end
    end

    task automatic drive_request(input stim_row_t row);
        fib_rsp_t want;
        want     = row.want;
        want.tag = next_tag;
        expected.push_back(want);
        req_valid  = 1'b1;
        req_prefix = row.prefix;
        req_len    = row.len;
        req_tag    = next_tag;
        next_tag   = next_tag + 1'b1;
        sent_count++;
    endtask

    task automatic send_lookup(input stim_row_t row);
        int waited;
        waited = 0;
        while (upstream_credits() == 0) begin
            req_valid = 1'b0;
            @(negedge clk);
            waited++;
            if (waited > wait_limit) begin
                $display("Timed out waiting for req_credit before tag %0d", next_tag);
                abort_run();
            end
        end
        drive_request(row);
        @(negedge clk);
    endtask

    task automatic write_entry(input stim_row_t row);
        cfg_write  = 1'b1;
        cfg_index  = row.index;
        cfg_valid  = row.valid;
        cfg_prefix = row.prefix;
        cfg_len    = row.len;
        cfg_face   = row.face;
        @(negedge clk);
        cfg_write = 1'b0;
    endtask

    // Waits until every response and every credit return has gone through
    task automatic drain();
        int waited;
        waited = 0;
        req_valid = 1'b0;
        while (expected.size() > 0 || return_due.size() > 0) begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) begin
                $display("Timed out draining, %0d responses still missing", expected.size());
                abort_run();
            end
        end
    endtask

    // Upstream keeps pushing while rsp_credit is withheld
    task automatic run_hold_phase();
        int rsp_before;
        int pulses_mid;
        int burst_sent;
        rsp_before   = rsp_count;
        pulses_mid   = 0;
        burst_sent   = 0;
        hold_credits = 1'b1;
        for (int c = 0; c < hold_cycles; c++) begin
            if (c == hold_cycles / 2) pulses_mid = credit_pulses;
            if (upstream_credits() > 0 && burst_sent < 16) begin
                drive_request(burst[burst_sent % burst.size()]);
                burst_sent++;
            end else begin
                req_valid = 1'b0;
            end
            @(negedge clk);
        end
        req_valid = 1'b0;
        check_count("rsp_valid cycles while credit withheld", rsp_count - rsp_before,
                    down_credits);
        check_count("req_credit pulses late in hold", credit_pulses - pulses_mid, 0);
        hold_credits = 1'b0;
    endtask

    initial begin
        void'($urandom(32'h88aeefa3));
        reset      = 1'b1;
        cfg_write  = 1'b0;
        cfg_index  = '0;
        cfg_valid  = 1'b0;
        cfg_prefix = '0;
        cfg_len    = '0;
        cfg_face   = '0;
        req_valid  = 1'b0;
        req_prefix = '0;
        req_len    = '0;
        req_tag    = '0;
        next_tag   = '0;

        // Nested routes 8, 16 and 48 bits under one name
        stim.push_back(cfg_row(3'd0, 1'b1, 64'hA100_0000_0000_0000, 6'd8, 4'd1));
        stim.push_back(cfg_row(3'd1, 1'b1, 64'hA1B2_0000_0000_0000, 6'd16, 4'd2));
        stim.push_back(cfg_row(3'd2, 1'b1, 64'hA1B2_C3D4_E5F6_0000, 6'd48, 4'd3));
        stim.push_back(lookup_row(name_p, 6'd63, 1'b1, 4'd3, 6'd48));
        stim.push_back(lookup_row(name_p, 6'd48, 1'b1, 4'd3, 6'd48));
        stim.push_back(lookup_row(name_p, 6'd40, 1'b1, 4'd2, 6'd16));
        stim.push_back(lookup_row(64'hA1B2_C3D4_E5F7_0718, 6'd63, 1'b1, 4'd2, 6'd16));
        stim.push_back(lookup_row(64'hA1B3_C3D4_E5F6_0718, 6'd63, 1'b1, 4'd1, 6'd8));
        stim.push_back(lookup_row(64'hB000_0000_0000_0000, 6'd63, 1'b0, 4'd0, 6'd0));
        stim.push_back(lookup_row(name_p, 6'd7, 1'b0, 4'd0, 6'd0));
        // Default route, and two 16 bit routes tying on 7700
        stim.push_back(cfg_row(3'd5, 1'b1, 64'h0, 6'd0, 4'd9));
        stim.push_back(cfg_row(3'd3, 1'b1, 64'h7700_0000_0000_0000, 6'd16, 4'd4));
        stim.push_back(cfg_row(3'd4, 1'b1, 64'h7700_0000_0000_0000, 6'd12, 4'd6));
        stim.push_back(cfg_row(3'd6, 1'b1, 64'h7700_1111_0000_0000, 6'd16, 4'd5));
        stim.push_back(lookup_row(64'hB000_0000_0000_0000, 6'd63, 1'b1, 4'd9, 6'd0));
        stim.push_back(lookup_row(name_p, 6'd7, 1'b1, 4'd9, 6'd0));
        stim.push_back(lookup_row(name_p, 6'd0, 1'b1, 4'd9, 6'd0));
        stim.push_back(lookup_row(64'h7700_2222_0000_0000, 6'd32, 1'b1, 4'd4, 6'd16));
        stim.push_back(lookup_row(64'h7700_2222_0000_0000, 6'd14, 1'b1, 4'd6, 6'd12));
        stim.push_back(lookup_row(name_p, 6'd63, 1'b1, 4'd3, 6'd48));
        // Delete and rewrite
        stim.push_back(cfg_row(3'd2, 1'b0, 64'hA1B2_C3D4_E5F6_0000, 6'd48, 4'd3));
        stim.push_back(lookup_row(name_p, 6'd63, 1'b1, 4'd2, 6'd16));
        stim.push_back(cfg_row(3'd1, 1'b1, 64'hA1B2_0000_0000_0000, 6'd16, 4'd7));
        stim.push_back(lookup_row(name_p, 6'd63, 1'b1, 4'd7, 6'd16));
        stim.push_back(cfg_row(3'd3, 1'b0, 64'h7700_0000_0000_0000, 6'd16, 4'd4));
        stim.push_back(lookup_row(64'h7700_2222_0000_0000, 6'd32, 1'b1, 4'd5, 6'd16));

        // Burst rows, answers from the final table
        burst.push_back(lookup_row(name_p, 6'd63, 1'b1, 4'd7, 6'd16));
        burst.push_back(lookup_row(64'h7700_0000_0000_0001, 6'd20, 1'b1, 4'd5, 6'd16));
        burst.push_back(lookup_row(64'hFFFF_0000_0000_0000, 6'd63, 1'b1, 4'd9, 6'd0));

        repeat (10) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        foreach (stim[i]) begin
            if (stim[i].is_cfg) begin
                drain();
                write_entry(stim[i]);
            end else begin
                send_lookup(stim[i]);
            end
        end
        drain();

        run_hold_phase();
        drain();

        check_count("req_credit pulses", credit_pulses, sent_count);
        check_count("rsp_valid cycles", rsp_count, sent_count);

        if (errors == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

`default_nettype wire

//--- fib.f
+incdir+testbench
src/fib_pkg.sv
src/fib_table_if.sv
src/fib_table_regs.sv
src/fib_credit_buffer.sv
src/fib_lpm_lookup.sv
src/fib.sv
testbench/fib_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the FIB testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module fib_tb -f fib.f -o fib_sim \
    && ./obj_dir/fib_sim > sim.log 2>&1 \
    || { echo "Build or simulation error"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "^TEST PASSED$" sim.log && echo "Simulation passed" && exit 0 \
    || { echo "Simulation failed"; exit 1; }
